/* decodeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall,
    input  mipsPkg::ifIdT     ifId,
    input  mipsPkg::exMemT    exMem,
    input  mipsPkg::memWbT    memWb,
    output mipsPkg::idExT     idEx,
    output logic              branchTaken,
    output mipsPkg::regUseT   regUse,
    output mipsPkg::regAddrT  rs,
    output mipsPkg::regAddrT  rt
);
    import mipsPkg::*;

    instrT ins;
    ctrlT  ctrl;
    wordT  rsRaw;
    wordT  rtRaw;
    wordT  rsFwd;
    wordT  rtFwd;

    assign ins = ifId.instr;
    assign rs  = ins.r.rs;
    assign rt  = ins.i.rt;

    regFile uRegFile (
        .clk    (clk),
        .rst    (rst),
        .rsAddr (rs),
        .rtAddr (rt),
        .wb     (memWb),
        .rsVal  (rsRaw),
        .rtVal  (rtRaw)
    );

    always_comb begin
        ctrl   = '0;
        regUse = '0;
        case (ins.r.op)
            opSpecial: begin
                // Anything else here, sll zero included, is a nop
                if (ins.r.funct == fnAddu || ins.r.funct == fnSubu) begin
                    ctrl.regWrite = 1'b1;
                    ctrl.aluOp    = (ins.r.funct == fnSubu) ? aluSub : aluAdd;
                    ctrl.dest     = ins.r.rd;
                    ctrl.tNew     = 2'd1;
                    regUse        = '{readRs: 1'b1, readRt: 1'b1, tUseRs: 2'd1, tUseRt: 2'd1};
                end
            end
            opOri, opLui: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.zeroExt   = (ins.i.op == opOri);
                ctrl.aluOp     = (ins.i.op == opOri) ? aluOr : aluLui;
                ctrl.dest      = ins.i.rt;
                ctrl.tNew      = 2'd1;
                regUse.readRs  = (ins.i.op == opOri);
                regUse.tUseRs  = 2'd1;
            end
            opLw: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memToReg  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.dest      = ins.i.rt;
                ctrl.tNew      = 2'd2;
                regUse.readRs  = 1'b1;
                regUse.tUseRs  = 2'd1;
            end
            opSw: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                // Store data is only needed in the memory stage
                regUse         = '{readRs: 1'b1, readRt: 1'b1, tUseRs: 2'd1, tUseRt: 2'd2};
            end
            opBeq: begin
                regUse = '{readRs: 1'b1, readRt: 1'b1, tUseRs: 2'd0, tUseRt: 2'd0};
            end
            default: ;
        endcase
    end

    assign rsFwd = fwdOperand(rs, rsRaw, exMem, memWb);
    assign rtFwd = fwdOperand(rt, rtRaw, exMem, memWb);

    // Ignored by fetch while stalled, so stale operands do no harm
    assign branchTaken = (ins.i.op == opBeq) && (rsFwd == rtFwd);

    always_ff @(posedge clk) begin
        idEx.pc    <= ifId.pc;
        idEx.instr <= ifId.instr;
        idEx.rsVal <= rsFwd;
        idEx.rtVal <= rtFwd;
        if (rst || stall) begin
            idEx.ctrl <= '0;
        end else begin
            idEx.ctrl <= ctrl;
        end
    end

endmodule

`default_nettype wire

/* executeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  logic            clk,
    input  logic            rst,
    input  mipsPkg::idExT   idEx,
    input  mipsPkg::memWbT  memWb,
    output mipsPkg::exMemT  exMem
);
    import mipsPkg::*;

    instrT ins;
    wordT  rsFwd;
    wordT  rtFwd;
    wordT  imm;
    wordT  srcB;
    wordT  result;

    assign ins   = idEx.instr;
    assign rsFwd = fwdOperand(ins.r.rs, idEx.rsVal, exMem, memWb);
    assign rtFwd = fwdOperand(ins.i.rt, idEx.rtVal, exMem, memWb);

    // Zero extension for ori only
    assign imm  = idEx.ctrl.zeroExt ? {16'h0000, ins.i.imm16}
                                    : {{16{ins.i.imm16[15]}}, ins.i.imm16};
    assign srcB = idEx.ctrl.aluSrcImm ? imm : rtFwd;

    always_comb begin
        case (idEx.ctrl.aluOp)
            aluSub:  result = rsFwd - srcB;
            aluOr:   result = rsFwd | srcB;
            aluLui:  result = {srcB[15:0], 16'h0000};
            default: result = rsFwd + srcB;
        endcase
    end

    always_ff @(posedge clk) begin
        exMem.pc        <= idEx.pc;
        exMem.result    <= result;
        exMem.storeData <= rtFwd;
        exMem.rt        <= ins.i.rt;
        if (rst) begin
            exMem.ctrl <= '0;
        end else begin
            exMem.ctrl      <= idEx.ctrl;
            exMem.ctrl.tNew <= (idEx.ctrl.tNew != 2'd0) ? idEx.ctrl.tNew - 2'd1 : 2'd0;
        end
    end

endmodule

`default_nettype wire

/* fetchStage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchStage #(
    parameter mipsPkg::wordT resetPc = 32'h3000
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           stall,
    input  logic           branchTaken,
    output mipsPkg::wordT  instrAddr,
    input  mipsPkg::wordT  instrRdata,
    output mipsPkg::ifIdT  ifId
);
    import mipsPkg::*;

    wordT pc;
    wordT branchTarget;
    wordT nextPc;

    // Target is relative to the delay slot, which sits at decode PC plus 4
    assign branchTarget = ifId.pc + 32'd4
                        + {{14{ifId.instr.i.imm16[15]}}, ifId.instr.i.imm16, 2'b00};
    assign nextPc       = branchTaken ? branchTarget : pc + 32'd4;
    assign instrAddr    = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc   <= resetPc;
            ifId <= '0;
        end else if (!stall) begin
            pc         <= nextPc;
            ifId.pc    <= pc;
            ifId.instr <= instrRdata;
        end
    end

endmodule

`default_nettype wire

/* hazardUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    input  mipsPkg::regUseT   regUse,
    input  mipsPkg::regAddrT  rs,
    input  mipsPkg::regAddrT  rt,
    input  mipsPkg::idExT     idEx,
    input  mipsPkg::exMemT    exMem,
    output logic              stall
);
    import mipsPkg::*;

    logic rsStall;
    logic rtStall;

    // Producer result not ready in time for this reader
    function automatic logic late(regAddrT r, logic [1:0] tUse, ctrlT prod);
        return r != '0 && prod.regWrite && prod.dest == r && prod.tNew > tUse;
    endfunction

    assign rsStall = regUse.readRs
                  && (late(rs, regUse.tUseRs, idEx.ctrl) || late(rs, regUse.tUseRs, exMem.ctrl));
    assign rtStall = regUse.readRt
                  && (late(rt, regUse.tUseRt, idEx.ctrl) || late(rt, regUse.tUseRt, exMem.ctrl));

    assign stall = rsStall || rtStall;

endmodule

`default_nettype wire

/* memoryStage.sv */
`timescale 1ns/1ps
`default_nettype none

module memoryStage (
    input  logic            clk,
    input  logic            rst,
    input  mipsPkg::exMemT  exMem,
    input  mipsPkg::wordT   dataRdata,
    output mipsPkg::wordT   dataAddr,
    output mipsPkg::wordT   dataWdata,
    output mipsPkg::wordT   memPc,
    output logic [3:0]      dataByteen,
    output mipsPkg::memWbT  memWb
);
    import mipsPkg::*;

    logic wbHit;

    // Catches a lw directly ahead of the sw that stores its result
    assign wbHit = memWb.regWrite && memWb.dest != '0 && memWb.dest == exMem.rt;

    assign dataAddr   = exMem.result;
    assign dataWdata  = wbHit ? memWb.result : exMem.storeData;
    assign dataByteen = exMem.ctrl.memWrite ? 4'hf : 4'h0;
    assign memPc      = exMem.pc;

    always_ff @(posedge clk) begin
        memWb.pc     <= exMem.pc;
        memWb.result <= exMem.ctrl.memToReg ? dataRdata : exMem.result;
        if (rst) begin
            memWb.dest     <= '0;
            memWb.regWrite <= 1'b0;
        end else begin
            memWb.dest     <= exMem.ctrl.dest;
            memWb.regWrite <= exMem.ctrl.regWrite;
        end
    end

endmodule

`default_nettype wire

/* mips.sv */
`timescale 1ns/1ps
`default_nettype none

module mips #(
    parameter mipsPkg::wordT resetPc = 32'h3000
) (
    input  logic              clk,
    input  logic              rst,
    // Instruction bus
    output mipsPkg::wordT     instrAddr,
    input  mipsPkg::wordT     instrRdata,
    // Data bus
    output mipsPkg::wordT     dataAddr,
    output mipsPkg::wordT     dataWdata,
    output logic [3:0]        dataByteen,
    output mipsPkg::wordT     memPc,
    input  mipsPkg::wordT     dataRdata,
    // Writeback trace
    output logic              grfWe,
    output mipsPkg::regAddrT  grfAddr,
    output mipsPkg::wordT     grfWdata,
    output mipsPkg::wordT     wbPc
);
    import mipsPkg::*;

    ifIdT    ifId;
    idExT    idEx;
    exMemT   exMem;
    memWbT   memWb;
    regUseT  regUse;
    regAddrT rsD;
    regAddrT rtD;
    logic    stall;
    logic    branchTaken;

    fetchStage #(.resetPc(resetPc)) uFetch (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .branchTaken (branchTaken),
        .instrAddr   (instrAddr),
        .instrRdata  (instrRdata),
        .ifId        (ifId)
    );

    decodeStage uDecode (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .ifId        (ifId),
        .exMem       (exMem),
        .memWb       (memWb),
        .idEx        (idEx),
        .branchTaken (branchTaken),
        .regUse      (regUse),
        .rs          (rsD),
        .rt          (rtD)
    );

    hazardUnit uHazard (
        .regUse (regUse),
        .rs     (rsD),
        .rt     (rtD),
        .idEx   (idEx),
        .exMem  (exMem),
        .stall  (stall)
    );

    executeStage uExecute (
        .clk   (clk),
        .rst   (rst),
        .idEx  (idEx),
        .memWb (memWb),
        .exMem (exMem)
    );

    memoryStage uMemory (
        .clk        (clk),
        .rst        (rst),
        .exMem      (exMem),
        .dataRdata  (dataRdata),
        .dataAddr   (dataAddr),
        .dataWdata  (dataWdata),
        .memPc      (memPc),
        .dataByteen (dataByteen),
        .memWb      (memWb)
    );

    // Register 0 writes never show on the trace
    assign grfWe    = memWb.regWrite && memWb.dest != '0;
    assign grfAddr  = memWb.dest;
    assign grfWdata = memWb.result;
    assign wbPc     = memWb.pc;

endmodule

`default_nettype wire

/* mipsPkg.sv */
`default_nettype none

package mipsPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regAddrT;

    typedef struct packed {
        logic [5:0] op;
        regAddrT    rs;
        regAddrT    rt;
        regAddrT    rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rTypeT;

    typedef struct packed {
        logic [5:0]  op;
        regAddrT     rs;
        regAddrT     rt;
        logic [15:0] imm16;
    } iTypeT;

    // One fetched word, seen either as R-type or as I-type
    typedef union packed {
        rTypeT r;
        iTypeT i;
    } instrT;

    typedef enum logic [1:0] {
        aluAdd,
        aluSub,
        aluOr,
        aluLui
    } aluOpT;

    typedef struct packed {
        logic       regWrite;
        logic       memWrite;
        logic       memToReg;
        logic       aluSrcImm;
        logic       zeroExt;
        aluOpT      aluOp;
        regAddrT    dest;
        logic [1:0] tNew;
    } ctrlT;

    // What the decode instruction reads, and how many cycles until it needs it
    typedef struct packed {
        logic       readRs;
        logic       readRt;
        logic [1:0] tUseRs;
        logic [1:0] tUseRt;
    } regUseT;

    typedef struct packed {
        wordT  pc;
        instrT instr;
    } ifIdT;

    typedef struct packed {
        wordT  pc;
        instrT instr;
        ctrlT  ctrl;
        wordT  rsVal;
        wordT  rtVal;
    } idExT;

    typedef struct packed {
        wordT    pc;
        ctrlT    ctrl;
        wordT    result;
        wordT    storeData;
        regAddrT rt;
    } exMemT;

    typedef struct packed {
        wordT    pc;
        regAddrT dest;
        logic    regWrite;
        wordT    result;
    } memWbT;

    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opOri     = 6'h0d;
    localparam logic [5:0] opLui     = 6'h0f;
    localparam logic [5:0] opLw      = 6'h23;
    localparam logic [5:0] opSw      = 6'h2b;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] fnAddu    = 6'h21;
    localparam logic [5:0] fnSubu    = 6'h23;

    // Newest ready value of register r; memory stage wins over writeback
    function automatic wordT fwdOperand(regAddrT r, wordT regVal, exMemT exMem, memWbT memWb);
        if (r != '0 && exMem.ctrl.regWrite && exMem.ctrl.tNew == 2'd0 && exMem.ctrl.dest == r)
            return exMem.result;
        else if (r != '0 && memWb.regWrite && memWb.dest == r)
            return memWb.result;
        else
            return regVal;
    endfunction

endpackage

`default_nettype wire

/* mipsTb.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsTb;
    import mipsPkg::*;

    localparam wordT resetPc = 32'h3000;

    typedef struct packed {
        wordT    pc;
        regAddrT dest;
        wordT    value;
    } wbEventT;

    typedef struct packed {
        wordT pc;
        wordT addr;
        wordT data;
    } stEventT;

    logic    clk;
    logic    rst;
    wordT    instrAddr;
    wordT    instrRdata;
    wordT    dataAddr;
    wordT    dataWdata;
    logic [3:0] dataByteen;
    wordT    memPc;
    wordT    dataRdata;
    logic    grfWe;
    regAddrT grfAddr;
    wordT    grfWdata;
    wordT    wbPc;

    wordT    imem [256];
    wordT    dmem [64];
    wordT    fetchOffset;
    int      progLen;
    integer  seed;
    wbEventT expWb [$];
    stEventT expSt [$];
    int      wbIdx;
    int      stIdx;

    tbClock uClock (
        .clk (clk)
    );

    mips #(.resetPc(resetPc)) UUT (
        .clk        (clk),
        .rst        (rst),
        .instrAddr  (instrAddr),
        .instrRdata (instrRdata),
        .dataAddr   (dataAddr),
        .dataWdata  (dataWdata),
        .dataByteen (dataByteen),
        .memPc      (memPc),
        .dataRdata  (dataRdata),
        .grfWe      (grfWe),
        .grfAddr    (grfAddr),
        .grfWdata   (grfWdata),
        .wbPc       (wbPc)
    );

    // Both memories answer in the same cycle
    assign fetchOffset = instrAddr - resetPc;
    assign instrRdata  = (fetchOffset < 32'd1024) ? imem[fetchOffset[9:2]] : 32'h0;
    assign dataRdata   = (dataAddr < 32'd256) ? dmem[dataAddr[7:2]] : 32'h0;

    function automatic wordT fillWord(logic [5:0] idx);
        wordT a;
        a = {24'h000000, idx, 2'b00};
        return (a * 32'h0001_0003) ^ 32'h5a5a_0000;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 64; i++) begin
                dmem[6'(i)] <= fillWord(6'(i));
            end
        end else if (dataByteen != 4'h0 && dataAddr < 32'd256) begin
            dmem[dataAddr[7:2]] <= dataWdata;
        end
    end

    function automatic wordT rWord(logic [5:0] funct, regAddrT rd, regAddrT rs, regAddrT rt);
        rTypeT w;
        w = '{op: opSpecial, rs: rs, rt: rt, rd: rd, shamt: 5'd0, funct: funct};
        return w;
    endfunction

    function automatic wordT iWord(logic [5:0] op, regAddrT rs, regAddrT rt, logic [15:0] imm);
        iTypeT w;
        w = '{op: op, rs: rs, rt: rt, imm16: imm};
        return w;
    endfunction

    // In-order ISA model with one delay slot
    function automatic void runReference(int nInstr);
        wordT    regs [32];
        wordT    mem [64];
        wordT    pc;
        wordT    npc;
        wordT    nnpc;
        wordT    sImm;
        wordT    addr;
        instrT   ins;
        wbEventT w;
        stEventT s;
        expWb.delete();
        expSt.delete();
        for (int i = 0; i < 32; i++) begin
            regs[5'(i)] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            mem[6'(i)] = fillWord(6'(i));
        end
        pc  = resetPc;
        npc = resetPc + 32'd4;
        while (pc < resetPc + 32'(4 * nInstr)) begin
            ins     = imem[8'((pc - resetPc) >> 2)];
            sImm    = {{16{ins.i.imm16[15]}}, ins.i.imm16};
            addr    = regs[ins.i.rs] + sImm;
            nnpc    = npc + 32'd4;
            w.pc    = pc;
            w.dest  = '0;
            w.value = '0;
            case (ins.r.op)
                opSpecial: begin
                    if (ins.r.funct == fnAddu) begin
                        w.dest  = ins.r.rd;
                        w.value = regs[ins.r.rs] + regs[ins.r.rt];
                    end else if (ins.r.funct == fnSubu) begin
                        w.dest  = ins.r.rd;
                        w.value = regs[ins.r.rs] - regs[ins.r.rt];
                    end
                end
                opOri: begin
                    w.dest  = ins.i.rt;
                    w.value = regs[ins.i.rs] | {16'h0000, ins.i.imm16};
                end
                opLui: begin
                    w.dest  = ins.i.rt;
                    w.value = {ins.i.imm16, 16'h0000};
                end
                opLw: begin
                    w.dest  = ins.i.rt;
                    w.value = (addr < 32'd256) ? mem[addr[7:2]] : 32'h0;
                end
                opSw: begin
                    s.pc   = pc;
                    s.addr = addr;
                    s.data = regs[ins.i.rt];
                    expSt.push_back(s);
                    if (addr < 32'd256) begin
                        mem[addr[7:2]] = s.data;
                    end
                end
                opBeq: begin
                    // Offset counts from the delay slot
                    if (regs[ins.i.rs] == regs[ins.i.rt]) begin
                        nnpc = pc + 32'd4 + {sImm[29:0], 2'b00};
                    end
                end
                default: ;
            endcase
            if (w.dest != '0) begin
                regs[w.dest] = w.value;
                expWb.push_back(w);
            end
            pc  = npc;
            npc = nnpc;
        end
    endfunction

    task automatic stopOnError(string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic reportMismatch(string name, wordT got, wordT want);
        stopOnError($sformatf("MISMATCH at %0t ns: %s got %h, expected %h",
                              $time, name, got, want));
    endtask

    task automatic checkWriteback(wordT pc, regAddrT dest, wordT value);
        wbEventT want;
        want = expWb[wbIdx];
        if (pc !== want.pc) begin
            reportMismatch("wbPc", pc, want.pc);
        end else if (dest !== want.dest) begin
            reportMismatch("grfAddr", 32'(dest), 32'(want.dest));
        end else if (value !== want.value) begin
            reportMismatch("grfWdata", value, want.value);
        end
    endtask

    task automatic checkStore(wordT pc, wordT addr, wordT data);
        stEventT want;
        want = expSt[stIdx];
        if (pc !== want.pc) begin
            reportMismatch("memPc", pc, want.pc);
        end else if (addr !== want.addr) begin
            reportMismatch("dataAddr", addr, want.addr);
        end else if (data !== want.data) begin
            reportMismatch("dataWdata", data, want.data);
        end
    endtask

    task automatic checkIdle(logic we, logic [3:0] byteen);
        if (we !== 1'b0) begin
            reportMismatch("grfWe", {31'h0, we}, 32'h0);
        end else if (byteen !== 4'h0) begin
            reportMismatch("dataByteen", {28'h0, byteen}, 32'h0);
        end
    endtask

    task automatic checkFetchAddr(wordT addr);
        if (addr !== resetPc) begin
            reportMismatch("instrAddr", addr, resetPc);
        end
    endtask

    // One expected event per register write or store
    always @(negedge clk) begin
        if (rst) begin
            wbIdx = 0;
            stIdx = 0;
        end else begin
            if (grfWe) begin
                if (wbIdx >= expWb.size()) begin
                    stopOnError($sformatf("Unexpected register write from pc %h", wbPc));
                end else begin
                    checkWriteback(wbPc, grfAddr, grfWdata);
                    wbIdx = wbIdx + 1;
                end
            end
            if (dataByteen != 4'h0) begin
                if (stIdx >= expSt.size()) begin
                    stopOnError($sformatf("Unexpected store from pc %h", memPc));
                end else begin
                    checkStore(memPc, dataAddr, dataWdata);
                    stIdx = stIdx + 1;
                end
            end
        end
    end

    task automatic emit(wordT w);
        imem[8'(progLen)] = w;
        progLen++;
    endtask

    task automatic resetAndClear();
        @(posedge clk);
        #1;
        rst = 1'b1;
        for (int a = 0; a < 256; a++) begin
            imem[8'(a)] = 32'h0;
        end
        progLen = 0;
    endtask

    task automatic runProgram(string name);
        int cycles;
        repeat (8) emit(32'h0000_0000);
        runReference(progLen);
        for (int k = 0; k < 10; k++) begin
            @(posedge clk);
            #1;
            checkIdle(grfWe, dataByteen);
        end
        rst = 1'b0;
        @(negedge clk);
        checkFetchAddr(instrAddr);
        checkIdle(grfWe, dataByteen);
        cycles = 0;
        while (wbIdx < expWb.size() || stIdx < expSt.size()) begin
            @(posedge clk);
            cycles++;
            if (cycles > 2000) begin
                stopOnError($sformatf("Timed out after 2000 cycles in program %s", name));
            end
        end
        // Quiet tail so stray writes still get caught
        repeat (8) @(posedge clk);
    endtask

    task automatic loadAluProgram();
        emit(iWord(opOri, 5'd0, 5'd1, 16'h1234));
        emit(rWord(fnAddu, 5'd2, 5'd1, 5'd1));
        emit(iWord(opOri, 5'd2, 5'd3, 16'h00f0));
        emit(rWord(fnSubu, 5'd4, 5'd3, 5'd1));
        emit(iWord(opLui, 5'd0, 5'd5, 16'habcd));
        emit(rWord(fnAddu, 5'd6, 5'd5, 5'd4));
        emit(iWord(opOri, 5'd6, 5'd7, 16'h8001));
        emit(rWord(fnSubu, 5'd1, 5'd7, 5'd2));
        emit(rWord(fnAddu, 5'd2, 5'd1, 5'd7));
        emit(rWord(fnSubu, 5'd3, 5'd0, 5'd2));
        emit(rWord(fnAddu, 5'd0, 5'd3, 5'd3));
        emit(rWord(fnAddu, 5'd4, 5'd0, 5'd1));
    endtask

    task automatic loadMemProgram();
        emit(iWord(opOri, 5'd0, 5'd1, 16'h0040));
        emit(iWord(opOri, 5'd0, 5'd2, 16'h5555));
        emit(iWord(opSw, 5'd1, 5'd2, 16'h0000));
        emit(iWord(opLw, 5'd1, 5'd3, 16'h0000));
        emit(rWord(fnAddu, 5'd4, 5'd3, 5'd2));
        emit(iWord(opLw, 5'd0, 5'd5, 16'h0008));
        emit(iWord(opSw, 5'd1, 5'd5, 16'h000c));
        emit(iWord(opLw, 5'd1, 5'd6, 16'h000c));
        emit(rWord(fnAddu, 5'd7, 5'd6, 5'd6));
        emit(iWord(opSw, 5'd1, 5'd7, 16'hfffc));
        emit(iWord(opLw, 5'd1, 5'd1, 16'h0004));
        emit(rWord(fnSubu, 5'd2, 5'd1, 5'd3));
        emit(iWord(opSw, 5'd0, 5'd2, 16'h0010));
    endtask

    task automatic loadBranchProgram();
        emit(iWord(opOri, 5'd0, 5'd1, 16'd5));
        emit(iWord(opOri, 5'd0, 5'd2, 16'd5));
        // Taken branch on r2 straight from the ALU
        emit(iWord(opBeq, 5'd1, 5'd2, 16'd2));
        emit(rWord(fnAddu, 5'd3, 5'd1, 5'd2));
        emit(iWord(opOri, 5'd0, 5'd4, 16'd1));
        emit(iWord(opOri, 5'd0, 5'd5, 16'd2));
        emit(iWord(opOri, 5'd0, 5'd6, 16'd3));
        // Not-taken branch on an operand loaded right before
        emit(iWord(opLw, 5'd0, 5'd7, 16'h0040));
        emit(iWord(opBeq, 5'd7, 5'd1, 16'd3));
        emit(iWord(opOri, 5'd0, 5'd3, 16'd7));
        emit(iWord(opOri, 5'd0, 5'd4, 16'd8));
        emit(iWord(opSw, 5'd0, 5'd1, 16'h0020));
        emit(iWord(opLw, 5'd0, 5'd7, 16'h0020));
        // Taken on a loaded operand, skips the ori after the delay slot
        emit(iWord(opBeq, 5'd7, 5'd2, 16'd2));
        emit(rWord(fnSubu, 5'd4, 5'd7, 5'd2));
        emit(iWord(opOri, 5'd0, 5'd5, 16'd9));
        emit(iWord(opOri, 5'd0, 5'd6, 16'd10));
    endtask

    // Registers 0 to 7, loads and stores based on r0, forward branches only
    task automatic loadRandomProgram(int count);
        wordT    r;
        regAddrT ra;
        regAddrT rb;
        regAddrT rc;
        logic    prevBeq;
        prevBeq = 1'b0;
        for (int n = 0; n < count; n++) begin
            r  = $random(seed);
            ra = {2'b00, r[2:0]};
            rb = {2'b00, r[5:3]};
            rc = {2'b00, r[8:6]};
            if (r[30:28] == 3'd7 && !prevBeq) begin
                emit(iWord(opBeq, ra, rb, {14'h0000, r[10:9]} + 16'd1));
                prevBeq = 1'b1;
            end else begin
                prevBeq = 1'b0;
                case (r[30:28])
                    3'd2:    emit(rWord(fnSubu, rc, ra, rb));
                    3'd3:    emit(iWord(opOri, ra, rb, r[24:9]));
                    3'd4:    emit(iWord(opLui, 5'd0, rb, r[24:9]));
                    3'd5:    emit(iWord(opLw, 5'd0, rb, {8'h00, r[14:9], 2'b00}));
                    3'd6:    emit(iWord(opSw, 5'd0, rb, {8'h00, r[14:9], 2'b00}));
                    default: emit(rWord(fnAddu, rc, ra, rb));
                endcase
            end
        end
    endtask

    initial begin
        seed    = 32'hf5ca;
        rst     = 1'b1;
        progLen = 0;
        resetAndClear();
        loadAluProgram();
        runProgram("alu chains");
        resetAndClear();
        loadMemProgram();
        runProgram("loads and stores");
        resetAndClear();
        loadBranchProgram();
        runProgram("branches");
        resetAndClear();
        loadRandomProgram(200);
        runProgram("random");
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

/* mips_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsAssertions (
    input  logic              clk,
    input  logic              rst,
    input  logic              grfWe,
    input  mipsPkg::regAddrT  grfAddr,
    input  logic [3:0]        dataByteen,
    input  mipsPkg::wordT     instrAddr
);

    weNotZeroReg: assert property (@(posedge clk) disable iff (rst)
        grfWe |-> grfAddr != 5'd0)
        else $error("register write reported for register 0");

    // Only whole-word stores exist
    byteenWholeWord: assert property (@(posedge clk) disable iff (rst)
        dataByteen == 4'h0 || dataByteen == 4'hf)
        else $error("dataByteen is neither empty nor full");

    quietInReset: assert property (@(posedge clk)
        (rst && $past(rst)) |-> (!grfWe && dataByteen == 4'h0))
        else $error("register write or store while in reset");

    pcWordAligned: assert property (@(posedge clk) disable iff (rst)
        instrAddr[1:0] == 2'b00)
        else $error("instrAddr is not word aligned");

endmodule

bind mips mipsAssertions uAssertions (
    .clk        (clk),
    .rst        (rst),
    .grfWe      (grfWe),
    .grfAddr    (grfAddr),
    .dataByteen (dataByteen),
    .instrAddr  (instrAddr)
);

`default_nettype wire

/* regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic              clk,
    input  logic              rst,
    input  mipsPkg::regAddrT  rsAddr,
    input  mipsPkg::regAddrT  rtAddr,
    input  mipsPkg::memWbT    wb,
    output mipsPkg::wordT     rsVal,
    output mipsPkg::wordT     rtVal
);
    import mipsPkg::*;

    wordT regs [32];
    logic writing;

    assign writing = wb.regWrite && wb.dest != '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writing) begin
            regs[wb.dest] <= wb.result;
        end
    end

    // Write-through so decode sees the value being written this cycle
    assign rsVal = (rsAddr == '0) ? '0 : (writing && wb.dest == rsAddr) ? wb.result : regs[rsAddr];
    assign rtVal = (rtAddr == '0) ? '0 : (writing && wb.dest == rtAddr) ? wb.result : regs[rtAddr];

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench; exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --assert -j 0 --top-module mipsTb -f vlog.f -o mipsSim &&
./obj_dir/mipsSim ||
exit 1

/* tbClock.sv */
`timescale 1ns/1ps
`default_nettype none

module tbClock (
    output logic clk
);

    // Starts low with a 4 ns period
    always begin
        clk = 1'b0;
        #2;
        clk = 1'b1;
        #2;
    end

endmodule

`default_nettype wire

/* vlog.f */
mipsPkg.sv
fetchStage.sv
regFile.sv
hazardUnit.sv
decodeStage.sv
executeStage.sv
memoryStage.sv
mips.sv
tbClock.sv
mips_assertions.sv
mipsTb.sv
